// ==== Bender.yml ====
package:
  name: pipe16

sources:
  - logic/pipe16_pkg.sv
  - logic/pipe16_ifs.sv
  - logic/fetch.sv
  - logic/regfile.sv
  - logic/decode.sv
  - logic/hazard_unit.sv
  - logic/execute.sv
  - logic/mem_stage.sv
  - logic/pipe16.sv
  - target: test
    files:
      - sim/pipe16_tb.sv

// ==== logic/decode.sv ====
/*
 * Decode stage: splits the instruction, reads the register file,
 * extends the immediates and loads the ID/EX register.
 * A load-use bubble or a branch flush loads an invalid entry.
 */
module decode (
   input  logic                 clk,
   input  logic                 rst_n,
   input  pipe16_pkg::word_t    instr,
   input  pipe16_pkg::word_t    pc_inc,
   input  logic                 valid,
   input  logic                 bubble,
   input  logic                 flush,
   input  logic                 wb_en,
   input  pipe16_pkg::reg_idx_t wb_reg,
   input  pipe16_pkg::word_t    wb_data,
   ex_stage_if.source           ex,
   output logic                 illegal,
   output pipe16_pkg::reg_idx_t rs_idx,
   output pipe16_pkg::reg_idx_t rt_idx,
   output logic                 uses_rt
);
   import pipe16_pkg::*;

   opcode_t  opcode;
   alu_fn_t  fn;
   alu_fn_t  alu_fn;
   reg_idx_t rd_idx;
   reg_idx_t dst;
   word_t    imm5_ext;
   word_t    imm8_ext;
   word_t    imm;
   word_t    rs_val;
   word_t    rt_val;
   wb_src_t  wb_src;
   logic     use_imm;
   logic     wr_en;
   logic     undefined;

   assign opcode   = opcode_t'(instr[op_msb:op_lsb]);
   assign rs_idx   = instr[rs_msb:rs_lsb];
   assign rt_idx   = instr[rt_msb:rt_lsb];
   assign rd_idx   = instr[rd_msb:rd_lsb];
   assign fn       = alu_fn_t'(instr[fn_msb:fn_lsb]);
   assign imm5_ext = word_t'(signed'(instr[imm5_msb:imm5_lsb]));
   assign imm8_ext = word_t'(signed'(instr[imm8_msb:imm8_lsb]));

   regfile rf_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .rd_idx_a  (rs_idx),
      .rd_idx_b  (rt_idx),
      .rd_data_a (rs_val),
      .rd_data_b (rt_val),
      .wr_en     (wb_en),
      .wr_idx    (wb_reg),
      .wr_data   (wb_data)
   );

   // Default is the rs + imm5 address form
   always_comb begin
      dst       = rd_idx;
      imm       = imm5_ext;
      alu_fn    = fn_add;
      use_imm   = 1'b1;
      wr_en     = 1'b0;
      wb_src    = src_alu;
      uses_rt   = 1'b0;
      undefined = 1'b0;
      case (opcode)
         op_alu: begin
            alu_fn  = fn;
            use_imm = 1'b0;
            wr_en   = 1'b1;
            uses_rt = 1'b1;
         end
         op_addi: begin
            dst   = rt_idx;
            wr_en = 1'b1;
         end
         op_lbi: begin
            dst    = rs_idx;
            imm    = imm8_ext;
            wr_en  = 1'b1;
            wb_src = src_imm;
         end
         op_ld: begin
            dst    = rt_idx;
            wr_en  = 1'b1;
            wb_src = src_mem;
         end
         op_st:            uses_rt = 1'b1;
         op_beqz, op_bnez: imm = imm8_ext;
         op_halt:          wr_en = 1'b0;
         default:          undefined = 1'b1;
      endcase
   end

   assign illegal = valid & ~flush & undefined;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ex.valid <= 1'b0;
      end else begin
         ex.valid <= valid & ~bubble & ~flush & ~undefined;
      end
   end

   always_ff @(posedge clk) begin
      ex.pc_inc  <= pc_inc;
      ex.op_a    <= rs_val;
      ex.op_b    <= rt_val;
      ex.rs      <= rs_idx;
      ex.rt      <= rt_idx;
      ex.imm     <= imm;
      ex.opcode  <= opcode;
      ex.alu_fn  <= alu_fn;
      ex.use_imm <= use_imm;
      ex.dst     <= dst;
      ex.wr_en   <= wr_en;
      ex.wb_src  <= wb_src;
   end

endmodule

// ==== logic/execute.sv ====
/*
 * Execute stage: operand forwarding, ALU, branch resolution and the
 * EX/MEM register. A taken branch redirects fetch and flushes the two
 * younger instructions. Nothing behind a HALT is passed on.
 */
module execute (
   input  logic                 clk,
   input  logic                 rst_n,
   ex_stage_if.sink             ex,
   input  pipe16_pkg::fwd_sel_t fwd_a,
   input  pipe16_pkg::fwd_sel_t fwd_b,
   input  pipe16_pkg::word_t    wb_data,
   input  logic                 stop,
   mem_stage_if.source          mem,
   output logic                 redirect,
   output pipe16_pkg::word_t    redirect_pc
);
   import pipe16_pkg::*;

   word_t mem_fwd_val;
   word_t op_a;
   word_t op_b;
   word_t alu_b;
   word_t alu_res;
   logic  block;
   logic  is_zero;

   function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val, word_t mem_val,
                                     word_t wb_val);
      case (sel)
         fwd_mem: return mem_val;
         fwd_wb:  return wb_val;
         default: return reg_val;
      endcase
   endfunction

   // HALT in memory or already retired
   assign block = stop | (mem.valid & mem.halt);

   assign mem_fwd_val = (mem.wb_src == src_imm) ? mem.imm : mem.alu_res;
   assign op_a        = fwd_mux(fwd_a, ex.op_a, mem_fwd_val, wb_data);
   assign op_b        = fwd_mux(fwd_b, ex.op_b, mem_fwd_val, wb_data);
   assign alu_b       = ex.use_imm ? ex.imm : op_b;

   always_comb begin
      case (ex.alu_fn)
         fn_add:  alu_res = op_a + alu_b;
         fn_sub:  alu_res = op_a - alu_b;
         fn_xor:  alu_res = op_a ^ alu_b;
         default: alu_res = op_a & ~alu_b;
      endcase
   end

   assign is_zero     = (op_a == '0);
   assign redirect    = ex.valid & ~block &
                        ((ex.opcode == op_beqz & is_zero) | (ex.opcode == op_bnez & ~is_zero));
   assign redirect_pc = ex.pc_inc + ex.imm;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         mem.valid <= 1'b0;
      end else begin
         mem.valid <= ex.valid & ~block;
      end
   end

   always_ff @(posedge clk) begin
      mem.alu_res <= alu_res;
      mem.st_data <= op_b;
      mem.dst     <= ex.dst;
      mem.wr_en   <= ex.wr_en;
      mem.load    <= (ex.opcode == op_ld);
      mem.store   <= (ex.opcode == op_st);
      mem.wb_src  <= ex.wb_src;
      mem.imm     <= ex.imm;
      mem.halt    <= (ex.opcode == op_halt);
   end

endmodule

// ==== logic/fetch.sv ====
/*
 * Fetch stage: program counter and the IF/ID register.
 * The PC steps by one word, holds on a load-use stall or after halt,
 * and takes the branch target from execute on a redirect.
 */
module fetch (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   stall,
   input  logic                   redirect,
   input  pipe16_pkg::word_t      redirect_pc,
   input  logic                   stop,
   output pipe16_pkg::imem_addr_t imem_addr,
   input  pipe16_pkg::word_t      imem_data,
   output pipe16_pkg::word_t      id_instr,
   output pipe16_pkg::word_t      id_pc_inc,
   output logic                   id_valid
);
   import pipe16_pkg::*;

   imem_addr_t pc;
   word_t      pc_inc;

   assign imem_addr = pc;
   assign pc_inc    = pc + 16'd1;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc       <= '0;
         id_valid <= 1'b0;
      end else if (stop) begin
         id_valid <= 1'b0;
      end else if (redirect) begin
         // Wrong-path fetch is dropped
         pc       <= redirect_pc;
         id_valid <= 1'b0;
      end else if (!stall) begin
         pc       <= pc_inc;
         id_valid <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         id_instr  <= imem_data;
         id_pc_inc <= pc_inc;
      end
   end

endmodule

// ==== logic/hazard_unit.sv ====
/*
 * Hazard detection and forwarding control.
 * Stalls decode one cycle behind a load whose result it needs and
 * picks, per execute operand, the memory stage or writeback as source.
 */
module hazard_unit (
   ex_stage_if.monitor            ex,
   mem_stage_if.monitor           mem,
   input  pipe16_pkg::reg_idx_t   id_rs,
   input  pipe16_pkg::reg_idx_t   id_rt,
   input  logic                   id_uses_rt,
   input  logic                   wb_en,
   input  pipe16_pkg::reg_idx_t   wb_reg,
   output logic                   stall,
   output pipe16_pkg::fwd_sel_t   fwd_a,
   output pipe16_pkg::fwd_sel_t   fwd_b
);
   import pipe16_pkg::*;

   logic mem_ok;

   // Younger producer wins
   function automatic fwd_sel_t pick(reg_idx_t src, logic m_ok, reg_idx_t m_dst,
                                     logic w_ok, reg_idx_t w_dst);
      if (m_ok && m_dst == src) begin
         return fwd_mem;
      end
      if (w_ok && w_dst == src) begin
         return fwd_wb;
      end
      return fwd_none;
   endfunction

   // Load data only exists from writeback on
   assign mem_ok = mem.valid & mem.wr_en & ~mem.load;

   assign fwd_a = pick(ex.rs, mem_ok, mem.dst, wb_en, wb_reg);
   assign fwd_b = pick(ex.rt, mem_ok, mem.dst, wb_en, wb_reg);

   assign stall = ex.valid && ex.opcode == op_ld &&
                  (ex.dst == id_rs || (id_uses_rt && ex.dst == id_rt));

endmodule

// ==== logic/mem_stage.sv ====
/*
 * Memory stage with the 256-word data memory and the MEM/WB register.
 * Loads read in the same cycle; the written value is picked from the
 * ALU result, the load data or the LBI immediate.
 */
module mem_stage (
   input  logic                 clk,
   input  logic                 rst_n,
   mem_stage_if.sink            mem,
   output logic                 wb_en,
   output pipe16_pkg::reg_idx_t wb_reg,
   output pipe16_pkg::word_t    wb_data,
   output logic                 halt_seen
);
   import pipe16_pkg::*;

   word_t      dmem [dmem_depth];
   dmem_addr_t addr;
   word_t      rd_data;
   word_t      result;

   // Word address, upper bits ignored
   assign addr    = mem.alu_res[$bits(dmem_addr_t)-1:0];
   assign rd_data = dmem[addr];

   always_ff @(posedge clk) begin
      if (mem.valid && mem.store) begin
         dmem[addr] <= mem.st_data;
      end
   end

   always_comb begin
      case (mem.wb_src)
         src_mem: result = rd_data;
         src_imm: result = mem.imm;
         default: result = mem.alu_res;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb_en <= 1'b0;
      end else begin
         wb_en <= mem.valid & mem.wr_en;
      end
   end

   always_ff @(posedge clk) begin
      wb_reg  <= mem.dst;
      wb_data <= result;
   end

   // HALT moving into MEM/WB this cycle
   assign halt_seen = mem.valid & mem.halt;

endmodule

// ==== logic/pipe16.sv ====
/*
 * Top level of the pipe16 in-order core.
 * Instructions come in on imem_data for the address on imem_addr in
 * the same cycle. Register writes show on the wb_* ports; halted and
 * err are sticky until reset.
 */
module pipe16 (
   input  logic                   clk,
   input  logic                   rst_n,
   output pipe16_pkg::imem_addr_t imem_addr,
   input  pipe16_pkg::word_t      imem_data,
   output logic                   wb_en,
   output pipe16_pkg::reg_idx_t   wb_reg,
   output pipe16_pkg::word_t      wb_data,
   output logic                   halted,
   output logic                   err
);
   import pipe16_pkg::*;

   logic     stall;
   logic     redirect;
   word_t    redirect_pc;
   word_t    id_instr;
   word_t    id_pc_inc;
   logic     id_valid;
   logic     illegal;
   reg_idx_t id_rs;
   reg_idx_t id_rt;
   logic     id_uses_rt;
   fwd_sel_t fwd_a;
   fwd_sel_t fwd_b;
   logic     halt_seen;

   ex_stage_if  ex_bus ();
   mem_stage_if mem_bus ();

   fetch fetch_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .stall       (stall),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .stop        (halted),
      .imem_addr   (imem_addr),
      .imem_data   (imem_data),
      .id_instr    (id_instr),
      .id_pc_inc   (id_pc_inc),
      .id_valid    (id_valid)
   );

   decode decode_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .instr   (id_instr),
      .pc_inc  (id_pc_inc),
      .valid   (id_valid),
      .bubble  (stall),
      .flush   (redirect),
      .wb_en   (wb_en),
      .wb_reg  (wb_reg),
      .wb_data (wb_data),
      .ex      (ex_bus.source),
      .illegal (illegal),
      .rs_idx  (id_rs),
      .rt_idx  (id_rt),
      .uses_rt (id_uses_rt)
   );

   hazard_unit hazard_i (
      .ex         (ex_bus.monitor),
      .mem        (mem_bus.monitor),
      .id_rs      (id_rs),
      .id_rt      (id_rt),
      .id_uses_rt (id_uses_rt),
      .wb_en      (wb_en),
      .wb_reg     (wb_reg),
      .stall      (stall),
      .fwd_a      (fwd_a),
      .fwd_b      (fwd_b)
   );

   execute execute_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .ex          (ex_bus.sink),
      .fwd_a       (fwd_a),
      .fwd_b       (fwd_b),
      .wb_data     (wb_data),
      .stop        (halted),
      .mem         (mem_bus.source),
      .redirect    (redirect),
      .redirect_pc (redirect_pc)
   );

   mem_stage mem_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .mem       (mem_bus.sink),
      .wb_en     (wb_en),
      .wb_reg    (wb_reg),
      .wb_data   (wb_data),
      .halt_seen (halt_seen)
   );

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         halted <= 1'b0;
         err    <= 1'b0;
      end else begin
         halted <= halted | halt_seen;
         err    <= err | illegal;
      end
   end

endmodule

// ==== logic/pipe16_ifs.sv ====
/*
 * Stage-to-stage bundles of the pipe16 core.
 * ex_stage_if is the ID/EX register as seen by execute and the hazard unit;
 * mem_stage_if is the EX/MEM register as seen by the memory stage.
 */
interface ex_stage_if;
   import pipe16_pkg::*;

   word_t    pc_inc;
   word_t    op_a;
   word_t    op_b;
   reg_idx_t rs;
   reg_idx_t rt;
   word_t    imm;
   opcode_t  opcode;
   alu_fn_t  alu_fn;
   logic     use_imm;
   reg_idx_t dst;
   logic     wr_en;
   wb_src_t  wb_src;
   logic     valid;

   modport source (output pc_inc, op_a, op_b, rs, rt, imm, opcode, alu_fn, use_imm, dst,
                   wr_en, wb_src, valid);
   modport sink (input pc_inc, op_a, op_b, rs, rt, imm, opcode, alu_fn, use_imm, dst,
                 wr_en, wb_src, valid);
   modport monitor (input valid, opcode, rs, rt, dst);
endinterface

interface mem_stage_if;
   import pipe16_pkg::*;

   word_t    alu_res;
   word_t    st_data;
   reg_idx_t dst;
   logic     wr_en;
   logic     load;
   logic     store;
   wb_src_t  wb_src;
   word_t    imm;
   logic     halt;
   logic     valid;

   modport source (output alu_res, st_data, dst, wr_en, load, store, wb_src, imm, halt, valid);
   modport sink (input alu_res, st_data, dst, wr_en, load, store, wb_src, imm, halt, valid);
   modport monitor (input valid, wr_en, load, dst);
endinterface

// ==== logic/pipe16_pkg.sv ====
/*
 * Shared types and constants for the pipe16 five-stage core.
 * Holds the data widths, the opcode and ALU function encodings,
 * the instruction field positions and the data memory depth.
 * Both the RTL and the testbench import it.
 */
package pipe16_pkg;

   typedef logic [15:0] word_t;
   typedef logic [2:0]  reg_idx_t;
   typedef logic [15:0] imem_addr_t;
   typedef logic [7:0]  dmem_addr_t;

   localparam int num_regs   = 8;
   localparam int dmem_depth = 256;

   // Instruction field positions
   localparam int op_msb   = 15;
   localparam int op_lsb   = 11;
   localparam int rs_msb   = 10;
   localparam int rs_lsb   = 8;
   localparam int rt_msb   = 7;
   localparam int rt_lsb   = 5;
   localparam int rd_msb   = 4;
   localparam int rd_lsb   = 2;
   localparam int fn_msb   = 1;
   localparam int fn_lsb   = 0;
   localparam int imm5_msb = 4;
   localparam int imm5_lsb = 0;
   localparam int imm8_msb = 7;
   localparam int imm8_lsb = 0;

   typedef enum logic [4:0] {
      op_halt = 5'b00000,
      op_addi = 5'b01000,
      op_beqz = 5'b01100,
      op_bnez = 5'b01101,
      op_st   = 5'b10000,
      op_ld   = 5'b10001,
      op_lbi  = 5'b11000,
      op_alu  = 5'b11011
   } opcode_t;

   // Function field of op_alu
   typedef enum logic [1:0] {
      fn_add  = 2'b00,
      fn_sub  = 2'b01,
      fn_xor  = 2'b10,
      fn_andn = 2'b11
   } alu_fn_t;

   typedef enum logic [1:0] {src_alu, src_mem, src_imm} wb_src_t;

   typedef enum logic [1:0] {fwd_none, fwd_mem, fwd_wb} fwd_sel_t;

endpackage

// ==== logic/regfile.sv ====
/*
 * Register file, eight 16-bit registers with two read ports.
 * A read of the register being written returns the new value,
 * so decode sees the writeback of the same cycle.
 */
module regfile (
   input  logic                 clk,
   input  logic                 rst_n,
   input  pipe16_pkg::reg_idx_t rd_idx_a,
   input  pipe16_pkg::reg_idx_t rd_idx_b,
   output pipe16_pkg::word_t    rd_data_a,
   output pipe16_pkg::word_t    rd_data_b,
   input  logic                 wr_en,
   input  pipe16_pkg::reg_idx_t wr_idx,
   input  pipe16_pkg::word_t    wr_data
);
   import pipe16_pkg::*;

   word_t regs [num_regs];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < num_regs; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_idx] <= wr_data;
      end
   end

   assign rd_data_a = (wr_en && wr_idx == rd_idx_a) ? wr_data : regs[rd_idx_a];
   assign rd_data_b = (wr_en && wr_idx == rd_idx_b) ? wr_data : regs[rd_idx_b];

endmodule

// ==== pipe16.f ====
logic/pipe16_pkg.sv
logic/pipe16_ifs.sv
logic/fetch.sv
logic/regfile.sv
logic/decode.sv
logic/hazard_unit.sv
logic/execute.sv
logic/mem_stage.sv
logic/pipe16.sv
sim/pipe16_tb.sv

// ==== sim/pipe16_tb.sv ====
/*
 * Testbench for the pipe16 core.
 * Each test builds a small program, runs it through an instruction-level
 * reference model to get the expected register writes, then resets the DUT
 * and runs it until halted. Concurrent assertions compare every writeback
 * with the model and watch the halted and err flags.
 */
module pipe16_tb;
   import pipe16_pkg::*;

   localparam int max_writes = 64;
   localparam int max_steps  = 500;

   logic       clk;
   logic       rst_n;
   imem_addr_t imem_addr;
   word_t      imem_data;
   logic       wb_en;
   reg_idx_t   wb_reg;
   word_t      wb_data;
   logic       halted;
   logic       err;

   word_t       prog [256];
   int          prog_len;
   word_t       model_regs [num_regs];
   word_t       model_mem [dmem_depth];
   logic        model_err;
   reg_idx_t    exp_reg [max_writes];
   word_t       exp_data [max_writes];
   int          exp_count;
   int          exp_ptr = 0;
   reg_idx_t    want_reg;
   word_t       want_data;
   logic        err_allowed;
   int          fail_count;
   int          test_count;
   int          cycles;
   int          cycle_limit = 0;
   logic [31:0] rng_state;

   pipe16 dut_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .imem_addr (imem_addr),
      .imem_data (imem_data),
      .wb_en     (wb_en),
      .wb_reg    (wb_reg),
      .wb_data   (wb_data),
      .halted    (halted),
      .err       (err)
   );

   always #2 clk = ~clk;

   // Program memory, HALT beyond the array
   assign imem_data = (imem_addr < 16'd256) ? prog[imem_addr[7:0]] : {op_halt, 11'd0};

   assign want_reg  = exp_reg[exp_ptr];
   assign want_data = exp_data[exp_ptr];

   always @(posedge clk) begin
      if (!rst_n) begin
         exp_ptr <= 0;
      end else if (wb_en) begin
         exp_ptr <= exp_ptr + 1;
      end
   end

   always @(posedge clk) begin
      if (rst_n) begin
         cycles = cycles + 1;
         if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT did not reach halt", cycles);
            $display("Verification failed");
            $finish;
         end
      end
   end

   write_expected: assert property (@(posedge clk) disable iff (!rst_n)
      wb_en |-> exp_ptr < exp_count)
      else begin
         $display("Register write to r%0d with no write left in the expected list",
                  $sampled(wb_reg));
         fail_count++;
      end

   write_reg_ok: assert property (@(posedge clk) disable iff (!rst_n)
      (wb_en && exp_ptr < exp_count) |-> wb_reg == want_reg)
      else begin
         $display("FAIL wb_reg: got %h, expected %h", $sampled(wb_reg), $sampled(want_reg));
         fail_count++;
      end

   write_data_ok: assert property (@(posedge clk) disable iff (!rst_n)
      (wb_en && exp_ptr < exp_count) |-> wb_data == want_data)
      else begin
         $display("FAIL wb_data: got %h, expected %h", $sampled(wb_data),
                  $sampled(want_data));
         fail_count++;
      end

   halted_sticky: assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
      else begin
         $display("halted dropped again before reset");
         fail_count++;
      end

   quiet_after_halt: assert property (@(posedge clk) disable iff (!rst_n) halted |-> !wb_en)
      else begin
         $display("Register write seen while halted");
         fail_count++;
      end

   // Fetch address frozen once halted
   pc_frozen: assert property (@(posedge clk) disable iff (!rst_n)
      halted |=> $stable(imem_addr))
      else begin
         $display("FAIL imem_addr: got %h, expected %h", $sampled(imem_addr),
                  $past(imem_addr));
         fail_count++;
      end

   err_low: assert property (@(posedge clk) disable iff (!rst_n) !err_allowed |-> !err)
      else begin
         $display("err rose in a program with only defined opcodes");
         fail_count++;
      end

   err_sticky: assert property (@(posedge clk) disable iff (!rst_n) err |=> err)
      else begin
         $display("err dropped again before reset");
         fail_count++;
      end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] draw_random();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   function automatic word_t r_type(alu_fn_t fn, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd);
      word_t w;
      w = '0;
      w[op_msb:op_lsb] = op_alu;
      w[rs_msb:rs_lsb] = rs;
      w[rt_msb:rt_lsb] = rt;
      w[rd_msb:rd_lsb] = rd;
      w[fn_msb:fn_lsb] = fn;
      return w;
   endfunction

   function automatic word_t i_type(opcode_t op, reg_idx_t rs, reg_idx_t rt, logic [4:0] imm);
      word_t w;
      w = '0;
      w[op_msb:op_lsb]     = op;
      w[rs_msb:rs_lsb]     = rs;
      w[rt_msb:rt_lsb]     = rt;
      w[imm5_msb:imm5_lsb] = imm;
      return w;
   endfunction

   function automatic word_t bi_type(opcode_t op, reg_idx_t rs, logic [7:0] imm);
      word_t w;
      w = '0;
      w[op_msb:op_lsb]     = op;
      w[rs_msb:rs_lsb]     = rs;
      w[imm8_msb:imm8_lsb] = imm;
      return w;
   endfunction

   task automatic emit(input word_t w);
      prog[prog_len] = w;
      prog_len++;
   endtask

   task automatic record_write(input reg_idx_t idx, input word_t val);
      model_regs[idx]     = val;
      exp_reg[exp_count]  = idx;
      exp_data[exp_count] = val;
      exp_count++;
   endtask

   // Instruction-level model, also sizes the cycle budget
   task automatic run_model();
      word_t ins;
      word_t a;
      word_t b;
      word_t imm5;
      word_t imm8;
      word_t addr;
      word_t pc;
      int    steps;
      logic  running;
      for (int i = 0; i < num_regs; i++) begin
         model_regs[i] = '0;
      end
      exp_count = 0;
      model_err = 1'b0;
      pc        = '0;
      steps     = 0;
      running   = 1'b1;
      while (running && steps < max_steps) begin
         ins  = (pc < 16'd256) ? prog[pc[7:0]] : '0;
         a    = model_regs[ins[rs_msb:rs_lsb]];
         b    = model_regs[ins[rt_msb:rt_lsb]];
         imm5 = {{11{ins[imm5_msb]}}, ins[imm5_msb:imm5_lsb]};
         imm8 = {{8{ins[imm8_msb]}}, ins[imm8_msb:imm8_lsb]};
         addr = a + imm5;
         steps++;
         pc = pc + 16'd1;
         case (ins[op_msb:op_lsb])
            op_halt: running = 1'b0;
            op_alu: begin
               case (ins[fn_msb:fn_lsb])
                  fn_add:  record_write(ins[rd_msb:rd_lsb], a + b);
                  fn_sub:  record_write(ins[rd_msb:rd_lsb], a - b);
                  fn_xor:  record_write(ins[rd_msb:rd_lsb], a ^ b);
                  default: record_write(ins[rd_msb:rd_lsb], a & ~b);
               endcase
            end
            op_addi: record_write(ins[rt_msb:rt_lsb], addr);
            op_lbi:  record_write(ins[rs_msb:rs_lsb], imm8);
            op_ld:   record_write(ins[rt_msb:rt_lsb], model_mem[addr[7:0]]);
            op_st:   model_mem[addr[7:0]] = b;
            op_beqz: pc = (a == '0) ? pc + imm8 : pc;
            op_bnez: pc = (a != '0) ? pc + imm8 : pc;
            // Undefined opcodes retire as no-ops
            default: model_err = 1'b1;
         endcase
      end
      cycle_limit = cycle_limit + 2 * steps + 10;
   endtask

   task automatic start_test();
      @(negedge clk);
      rst_n = 1'b0;
      for (int a = 0; a < 256; a++) begin
         prog[a] = {op_halt, 3'b000, 8'(a)};
      end
      prog_len = 0;
   endtask

   task automatic run_program(input string name);
      int fails_before;
      fails_before = fail_count;
      run_model();
      err_allowed = model_err;
      repeat (3) @(negedge clk);
      rst_n = 1'b1;
      while (!halted) begin
         @(negedge clk);
      end
      repeat (3) @(negedge clk);
      write_count: assert (exp_ptr == exp_count)
         else begin
            $display("Only %0d of %0d expected register writes were seen", exp_ptr, exp_count);
            fail_count++;
         end
      if (model_err) begin
         err_raised: assert (err)
            else begin
               $display("err did not rise for the undefined opcode");
               fail_count++;
            end
      end
      test_count++;
      $display("Test %0d, %s: %0d of %0d writes, %0d failed checks", test_count, name,
               exp_ptr, exp_count, fail_count - fails_before);
   endtask

   // rs reads the previous result, rt the one before it
   task automatic alu_chain_test();
      reg_idx_t    p;
      reg_idx_t    q;
      reg_idx_t    d;
      logic [31:0] r;
      start_test();
      r = draw_random();
      emit(bi_type(op_lbi, 3'd1, r[7:0]));
      emit(bi_type(op_lbi, 3'd2, r[15:8]));
      p = 3'd2;
      q = 3'd1;
      for (int k = 0; k < 10; k++) begin
         r = draw_random();
         d = reg_idx_t'(3 + k % 5);
         if (k % 2 == 0) begin
            emit(r_type(alu_fn_t'(r[1:0]), p, q, d));
         end else begin
            emit(i_type(op_addi, p, d, r[12:8]));
         end
         q = p;
         p = d;
      end
      run_program("dependent ALU chain");
   endtask

   task automatic load_use_test();
      logic [31:0] r;
      start_test();
      r = draw_random();
      emit(bi_type(op_lbi, 3'd1, 8'h20));
      emit(bi_type(op_lbi, 3'd2, r[7:0]));
      emit(i_type(op_st, 3'd1, 3'd2, 5'd3));
      emit(i_type(op_ld, 3'd1, 3'd3, 5'd3));
      emit(r_type(fn_add, 3'd3, 3'd2, 3'd4));
      emit(i_type(op_ld, 3'd1, 3'd5, 5'd3));
      emit(i_type(op_st, 3'd1, 3'd5, 5'd4));
      emit(i_type(op_ld, 3'd1, 3'd6, 5'd4));
      emit(i_type(op_addi, 3'd6, 3'd7, 5'd1));
      run_program("load-use");
   endtask

   task automatic branch_test();
      start_test();
      emit(bi_type(op_lbi, 3'd1, 8'd3));
      emit(bi_type(op_lbi, 3'd2, 8'd0));
      // Loop body runs three times
      emit(i_type(op_addi, 3'd2, 3'd2, 5'd5));
      emit(i_type(op_addi, 3'd1, 3'd1, 5'h1f));
      emit(bi_type(op_bnez, 3'd1, 8'hfd));
      emit(bi_type(op_beqz, 3'd1, 8'd2));
      emit(bi_type(op_lbi, 3'd3, 8'h11));
      emit(bi_type(op_lbi, 3'd4, 8'h22));
      emit(bi_type(op_bnez, 3'd1, 8'd2));
      emit(bi_type(op_lbi, 3'd5, 8'h33));
      emit(bi_type(op_beqz, 3'd5, 8'd1));
      emit(bi_type(op_lbi, 3'd6, 8'h44));
      emit(bi_type(op_bnez, 3'd6, 8'd2));
      emit(bi_type(op_lbi, 3'd3, 8'h55));
      emit(bi_type(op_lbi, 3'd4, 8'h66));
      run_program("branches");
   endtask

   task automatic lbi_sign_test();
      logic [31:0] r;
      start_test();
      r = draw_random();
      emit(bi_type(op_lbi, 3'd0, 8'h80));
      emit(bi_type(op_lbi, 3'd1, 8'hff));
      emit(bi_type(op_lbi, 3'd2, r[7:0] | 8'h80));
      emit(r_type(fn_add, 3'd0, 3'd1, 3'd3));
      emit(bi_type(op_lbi, 3'd0, 8'hc5));
      emit(r_type(fn_sub, 3'd0, 3'd2, 3'd4));
      run_program("LBI sign extension");
   endtask

   // The store behind HALT must not reach memory, the next test reads it back
   task automatic halt_test();
      start_test();
      emit(bi_type(op_lbi, 3'd1, 8'd7));
      emit(i_type(op_addi, 3'd1, 3'd2, 5'd1));
      emit(i_type(op_st, 3'd0, 3'd1, 5'd10));
      emit({op_halt, 11'd0});
      emit(i_type(op_st, 3'd0, 3'd2, 5'd10));
      emit(bi_type(op_lbi, 3'd3, 8'd9));
      emit(i_type(op_addi, 3'd1, 3'd4, 5'd2));
      run_program("HALT");
   endtask

   task automatic undefined_op_test();
      start_test();
      emit(bi_type(op_lbi, 3'd1, 8'd5));
      emit(i_type(op_ld, 3'd0, 3'd2, 5'd10));
      emit(16'hf8e3);
      emit(bi_type(op_lbi, 3'd3, 8'd7));
      emit(i_type(op_addi, 3'd2, 3'd4, 5'd1));
      run_program("undefined opcode");
   endtask

   initial begin
      clk         = 1'b0;
      rst_n       = 1'b0;
      err_allowed = 1'b0;
      fail_count  = 0;
      test_count  = 0;
      cycles      = 0;
      prog_len    = 0;
      rng_state   = 32'ha0bc_f833;
      for (int a = 0; a < 256; a++) begin
         prog[a] = {op_halt, 3'b000, 8'(a)};
      end

      alu_chain_test();
      load_use_test();
      branch_test();
      lbi_sign_test();
      halt_test();
      undefined_op_test();

      $display("Tests run: %0d, failed checks: %0d", test_count, fail_count);
      if (fail_count == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule
